// ==== source/enc_params.svh ====
`ifndef ENC_PARAMS_SVH
`define ENC_PARAMS_SVH

// Byte and line code widths
`define ENC_DATA_W 8
`define ENC_CODE_W 10

// K28.5 comma, sent in place of data while the lane is idle
`define ENC_IDLE_BYTE 8'b101_11100

`endif

// ==== source/line_code_pkg.sv ====
`include "enc_params.svh"

package line_code_pkg;

    // How the positive disparity code is formed from the negative one
    typedef enum logic [1:0] {
        inv_special = 2'b00,  // Flip g and h if special is set
        inv_low6    = 2'b01,  // Complement abcdei
        inv_high4   = 2'b10,  // Complement fghj
        inv_both    = 2'b11   // Complement the whole code
    } invert_t;

    // One entry of the code lookup, 16 bits
    // The code field keeps a in bit 0 and j in bit 9, the first bit sent
    // on the line is bit 0
    typedef struct packed {
        logic                   k_allowed;  // Byte is a legal K value
        logic                   k_neutral;  // K code is balanced
        logic                   special;    // Alternate 3b/4b swap
        invert_t                invert;
        logic                   neutral;    // D code is balanced
        logic [`ENC_CODE_W-1:0] code;       // Form for negative disparity
    } code_entry_t;

endpackage

// ==== source/lane_pkg.sv ====
`include "enc_params.svh"

package lane_pkg;

    // Byte entering the encoder pipeline
    typedef struct packed {
        logic                   is_k;  // Control symbol
        logic [`ENC_DATA_W-1:0] data;  // HGF EDCBA
    } symbol_t;

    // Registered lane result, 12 bits
    typedef struct packed {
        logic [`ENC_CODE_W-1:0] code;   // 10b word, bit 0 sent first
        logic                   kerr;   // K flag on an illegal byte
        logic                   valid;  // Word carries a real symbol
    } lane_out_t;

endpackage

// ==== source/symbol_intake.sv ====
`timescale 1ns/1ns
`include "enc_params.svh"

module symbol_intake (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   ena,
    input  logic                   idle_ins,
    input  logic                   kin,
    input  logic [`ENC_DATA_W-1:0] datain,
    output lane_pkg::symbol_t      sym_d1,
    output logic                   k_d2,
    output logic                   valid_pre1
);

    logic valid_pre2;  // First stage of the valid pipe

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sym_d1     <= '0;
            k_d2       <= 1'b0;
            valid_pre2 <= 1'b0;
            valid_pre1 <= 1'b0;
        end else begin
            sym_d1.data <= ena ? datain : `ENC_IDLE_BYTE;  // Comma when disabled
            sym_d1.is_k <= kin | ~ena;
            k_d2        <= sym_d1.is_k;  // Lines up with the table registers
            valid_pre2  <= ena | idle_ins;
            valid_pre1  <= valid_pre2;
        end
    end

    // A word may only be marked valid for a cycle that was enabled or idle-filled
    property p_valid_source;
        @(posedge clk) disable iff (!reset_n)
            $rose(valid_pre1) |-> $past(ena | idle_ins, 2);
    endproperty

    a_valid_source: assert property (p_valid_source)
        else $error("valid_pre1 rose without ena or idle_ins two cycles earlier");

endmodule

// ==== source/data_code_lut.sv ====
`timescale 1ns/1ns
`include "enc_params.svh"

module data_code_lut (
    input  logic                       clk,
    input  logic                       reset_n,
    input  lane_pkg::symbol_t          sym,
    output line_code_pkg::code_entry_t entry
);

    logic [4:0]                 x_field;     // EDCBA
    logic [2:0]                 y_field;     // HGF
    logic [5:0]                 abcdei;      // 6b group in line order
    logic [3:0]                 fghj_n;      // 4b group after negative disparity
    logic [3:0]                 fghj;        // 4b group as placed in the code
    logic                       bal6;
    logic                       bal4;
    logic                       alt7;
    logic                       x_is_7;
    logic                       flip4;
    logic                       flip6;
    logic                       special;
    logic                       k_legal;
    line_code_pkg::code_entry_t entry_next;

    assign x_field = sym.data[4:0];
    assign y_field = sym.data[7:5];

    // 5b/6b table, negative disparity column
    always_comb begin
        case (x_field)
            5'd0:    abcdei = 6'b100111;
            5'd1:    abcdei = 6'b011101;
            5'd2:    abcdei = 6'b101101;
            5'd3:    abcdei = 6'b110001;
            5'd4:    abcdei = 6'b110101;
            5'd5:    abcdei = 6'b101001;
            5'd6:    abcdei = 6'b011001;
            5'd7:    abcdei = 6'b111000;
            5'd8:    abcdei = 6'b111001;
            5'd9:    abcdei = 6'b100101;
            5'd10:   abcdei = 6'b010101;
            5'd11:   abcdei = 6'b110100;
            5'd12:   abcdei = 6'b001101;
            5'd13:   abcdei = 6'b101100;
            5'd14:   abcdei = 6'b011100;
            5'd15:   abcdei = 6'b010111;
            5'd16:   abcdei = 6'b011011;
            5'd17:   abcdei = 6'b100011;
            5'd18:   abcdei = 6'b010011;
            5'd19:   abcdei = 6'b110010;
            5'd20:   abcdei = 6'b001011;
            5'd21:   abcdei = 6'b101010;
            5'd22:   abcdei = 6'b011010;
            5'd23:   abcdei = 6'b111010;
            5'd24:   abcdei = 6'b110011;
            5'd25:   abcdei = 6'b100110;
            5'd26:   abcdei = 6'b010110;
            5'd27:   abcdei = 6'b110110;
            5'd28:   abcdei = 6'b001110;
            5'd29:   abcdei = 6'b101110;
            5'd30:   abcdei = 6'b011110;
            default: abcdei = 6'b101011;
        endcase
    end

    // A7 replaces P7 after negative disparity for x = 17, 18, 20
    assign alt7 = (x_field == 5'd17) || (x_field == 5'd18) || (x_field == 5'd20);

    // 3b/4b table, negative disparity column
    always_comb begin
        case (y_field)
            3'd0:    fghj_n = 4'b1011;
            3'd1:    fghj_n = 4'b1001;
            3'd2:    fghj_n = 4'b0101;
            3'd3:    fghj_n = 4'b1100;
            3'd4:    fghj_n = 4'b1101;
            3'd5:    fghj_n = 4'b1010;
            3'd6:    fghj_n = 4'b0110;
            default: fghj_n = alt7 ? 4'b0111 : 4'b1110;
        endcase
    end

    assign bal6   = ($countones(abcdei) == 3);
    assign x_is_7 = (x_field == 5'd7);  // Balanced but has two forms
    assign flip6  = ~bal6 | x_is_7;

    // y = 0, 3, 4, 7 have complementary 4b forms
    assign flip4 = (y_field == 3'd0) || (y_field == 3'd3) ||
                   (y_field == 3'd4) || (y_field == 3'd7);

    // An unbalanced 6b group leaves positive disparity for the 4b group
    assign fghj = (~bal6 & flip4) ? ~fghj_n : fghj_n;
    assign bal4 = ($countones(fghj) == 2);

    // Dx.7 pairs that swap between P7 and A7
    assign special = (y_field == 3'd7) &&
                     (alt7 || (x_field == 5'd11) || (x_field == 5'd13) || (x_field == 5'd14));

    // K28.y and the four Kx.7 codes
    assign k_legal = (x_field == 5'd28) ||
                     ((y_field == 3'd7) && ((x_field == 5'd23) || (x_field == 5'd27) ||
                                            (x_field == 5'd29) || (x_field == 5'd30)));

    always_comb begin
        entry_next.k_allowed = sym.is_k & k_legal;
        // Balanced K codes, the 10b error pattern of FF included
        entry_next.k_neutral = sym.is_k &
                               ((k_legal && (x_field != 5'd28)) ||
                                ((x_field == 5'd28) && ((y_field == 3'd0) ||
                                                        (y_field == 3'd4) ||
                                                        (y_field == 3'd7))) ||
                                (sym.data == 8'hFF));
        entry_next.special   = special;
        entry_next.invert    = special ? line_code_pkg::inv_special :
                                         line_code_pkg::invert_t'({flip4, flip6});
        entry_next.neutral   = (bal6 == bal4);  // 3+2 or 4+1 ones
        entry_next.code      = {<<{abcdei, fghj}};  // a lands in bit 0
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            entry <= '0;
        end else begin
            entry <= entry_next;
        end
    end

endmodule

// ==== source/ctrl_code_table.sv ====
`timescale 1ns/1ns
`include "enc_params.svh"

module ctrl_code_table (
    input  logic                   clk,
    input  logic                   reset_n,
    input  lane_pkg::symbol_t      sym,
    output logic [`ENC_CODE_W-1:0] ctrl_code
);

    logic [`ENC_CODE_W-1:0] code_next;  // jhgf_iedcba, negative disparity

    always_comb begin
        case (sym.data)
            8'b000_11100: code_next = 10'b0010_111100;  // K28.0
            8'b001_11100: code_next = 10'b1001_111100;  // K28.1
            8'b010_11100: code_next = 10'b1010_111100;  // K28.2
            8'b011_11100: code_next = 10'b1100_111100;  // K28.3
            8'b100_11100: code_next = 10'b0100_111100;  // K28.4
            8'b101_11100: code_next = 10'b0101_111100;  // K28.5
            8'b110_11100: code_next = 10'b0110_111100;  // K28.6
            8'b111_11100: code_next = 10'b0001_111100;  // K28.7
            8'b111_10111: code_next = 10'b0001_010111;  // K23.7
            8'b111_11011: code_next = 10'b0001_011011;  // K27.7
            8'b111_11101: code_next = 10'b0001_011101;  // K29.7
            8'b111_11110: code_next = 10'b0001_011110;  // K30.7
            8'b111_11111: code_next = 10'b1000_111100;  // 10b error pattern
            default:      code_next = 10'b0101_111100;  // Fall back to K28.5
        endcase
    end

    // Only control symbols read this register, so it holds on data bytes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_code <= '0;
        end else if (sym.is_k) begin
            ctrl_code <= code_next;
        end
    end

endmodule

// ==== source/disparity_select.sv ====
`timescale 1ns/1ns
`include "enc_params.svh"

module disparity_select (
    input  logic                       clk,
    input  logic                       reset_n,
    input  line_code_pkg::code_entry_t data_entry,
    input  logic [`ENC_CODE_W-1:0]     ctrl_code,
    input  logic                       k_d2,
    input  logic                       valid_pre1,
    input  logic                       rdin,
    input  logic                       rdforce,
    output lane_pkg::lane_out_t        lane_out,
    output logic                       rdout,
    output logic                       rdcascade
);

    logic                   rd;           // Disparity in effect for this word
    logic [`ENC_CODE_W-1:0] code_neg;
    logic [`ENC_CODE_W-1:0] code_pos;
    logic [`ENC_CODE_W-1:0] code_sel;
    line_code_pkg::invert_t inv_sel;
    logic                   special_sel;
    logic                   neutral_sel;

    assign rd = rdforce ? rdin : rdout;

    always_comb begin
        if (k_d2) begin
            code_neg    = ctrl_code;
            inv_sel     = line_code_pkg::inv_both;  // K codes mirror fully
            special_sel = 1'b0;
            neutral_sel = data_entry.k_neutral;
        end else begin
            code_neg    = data_entry.code;
            inv_sel     = data_entry.invert;
            special_sel = data_entry.special;
            neutral_sel = data_entry.neutral;
        end
    end

    // Positive disparity form
    always_comb begin
        case (inv_sel)
            line_code_pkg::inv_special:
                code_pos = {code_neg[9], code_neg[8] ^ special_sel,
                            code_neg[7] ^ special_sel, code_neg[6:0]};
            line_code_pkg::inv_low6:  code_pos = {code_neg[9:6], ~code_neg[5:0]};
            line_code_pkg::inv_high4: code_pos = {~code_neg[9:6], code_neg[5:0]};
            line_code_pkg::inv_both:  code_pos = ~code_neg;
            default:                  code_pos = ~code_neg;
        endcase
    end

    assign code_sel  = rd ? code_pos : code_neg;
    assign rdcascade = neutral_sel ^ ~rd;  // Unbalanced code toggles disparity

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_out <= '0;
            rdout    <= 1'b0;  // Start at negative disparity
        end else begin
            lane_out.code  <= code_sel;
            lane_out.kerr  <= k_d2 & ~data_entry.k_allowed;
            lane_out.valid <= valid_pre1;
            if (valid_pre1) begin
                rdout <= rdcascade;
            end
        end
    end

    // Every legal 10b word carries four to six ones
    property p_code_weight;
        @(posedge clk) disable iff (!reset_n)
            lane_out.valid |-> ($countones(lane_out.code) >= 4) &&
                               ($countones(lane_out.code) <= 6);
    endproperty

    a_code_weight: assert property (p_code_weight)
        else $error("output code has an illegal number of ones");

    // The table's neutral hint must agree with the word that leaves the lane
    property p_neutral_weight;
        @(posedge clk) disable iff (!reset_n)
            (valid_pre1 && neutral_sel) |=> ($countones(lane_out.code) == 5);
    endproperty

    a_neutral_weight: assert property (p_neutral_weight)
        else $error("neutral code does not have five ones");

endmodule

// ==== source/enc8b10b_lane.sv ====
`timescale 1ns/1ns
`include "enc_params.svh"

module enc8b10b_lane (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   idle_ins,
    input  logic                   kin,
    input  logic                   ena,
    input  logic [`ENC_DATA_W-1:0] datain,
    input  logic                   rdin,
    input  logic                   rdforce,
    output logic [`ENC_CODE_W-1:0] dataout,
    output logic                   kerr,
    output logic                   valid,
    output logic                   rdout,
    output logic                   rdcascade
);

    lane_pkg::symbol_t          sym_d1;
    logic                       k_d2;
    logic                       valid_pre1;
    line_code_pkg::code_entry_t data_entry;
    logic [`ENC_CODE_W-1:0]     ctrl_code;
    lane_pkg::lane_out_t        lane_out;

    symbol_intake symbol_intake_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .ena        (ena),
        .idle_ins   (idle_ins),
        .kin        (kin),
        .datain     (datain),
        .sym_d1     (sym_d1),
        .k_d2       (k_d2),
        .valid_pre1 (valid_pre1)
    );

    data_code_lut data_code_lut_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .sym     (sym_d1),
        .entry   (data_entry)
    );

    ctrl_code_table ctrl_code_table_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .sym       (sym_d1),
        .ctrl_code (ctrl_code)
    );

    disparity_select disparity_select_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .data_entry (data_entry),
        .ctrl_code  (ctrl_code),
        .k_d2       (k_d2),
        .valid_pre1 (valid_pre1),
        .rdin       (rdin),
        .rdforce    (rdforce),
        .lane_out   (lane_out),
        .rdout      (rdout),
        .rdcascade  (rdcascade)
    );

    assign dataout = lane_out.code;
    assign kerr    = lane_out.kerr;
    assign valid   = lane_out.valid;

endmodule

// ==== verification/enc8b10b_lane_tb.sv ====
`timescale 1ns/1ns

module enc8b10b_lane_tb;

    localparam int NUM_LINES     = 43;
    localparam int NUM_FIELDS    = 9;
    localparam int MAX_SLOTS     = 160;
    localparam int PIPE_DEPTH    = 3;   // Input edge to output register
    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 1000;

    logic       clk;
    logic       reset_n;
    logic       idle_ins;
    logic       kin;
    logic       ena;
    logic [7:0] datain;
    logic       rdin;
    logic       rdforce;
    logic [9:0] dataout;
    logic       kerr;
    logic       valid;
    logic       rdout;
    logic       rdcascade;

    logic [11:0] stim_mem [0:NUM_LINES*NUM_FIELDS-1];
    int          slot_line [0:MAX_SLOTS-1];  // -1 marks an empty cycle
    int          num_slots;
    int          exp_rd_now;                 // Disparity expected at rdout

    enc8b10b_lane enc8b10b_lane_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .idle_ins  (idle_ins),
        .kin       (kin),
        .ena       (ena),
        .datain    (datain),
        .rdin      (rdin),
        .rdforce   (rdforce),
        .dataout   (dataout),
        .kerr      (kerr),
        .valid     (valid),
        .rdout     (rdout),
        .rdcascade (rdcascade)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (actual !== expected) begin
            $display("[ERROR] time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            stop_run("output mismatch");
        end
    endtask

    function automatic int field(input int line, input int idx);
        return int'(stim_mem[line*NUM_FIELDS + idx]);
    endfunction

    function automatic int line_of(input int slot);
        if (slot < 0 || slot >= num_slots) begin
            return -1;
        end
        return slot_line[slot];
    endfunction

    function automatic int expect_valid(input int line);
        return field(line, 0) | field(line, 2);  // idle_ins or ena
    endfunction

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                stop_run("reset was never released");
            end
        end
    endtask

    task automatic drive_symbol(input int slot);
        int ln;
        ln = line_of(slot);
        if (ln < 0) begin
            idle_ins = 1'b0;
            kin      = 1'b0;
            ena      = 1'b0;
            datain   = 8'h00;
        end else begin
            idle_ins = field(ln, 0) != 0;
            kin      = field(ln, 1) != 0;
            ena      = field(ln, 2) != 0;
            datain   = 8'(field(ln, 3));
        end
    endtask

    // Disparity override belongs to the word now in the select stage
    task automatic drive_disparity(input int slot);
        int ln;
        ln = line_of(slot);
        if (ln < 0) begin
            rdforce = 1'b0;
            rdin    = 1'b0;
        end else begin
            rdforce = field(ln, 4) != 0;
            rdin    = field(ln, 5) != 0;
        end
    endtask

    task automatic check_output(input int slot);
        int ln;
        ln = line_of(slot);
        if (slot < 0) begin
            check_value("kerr", 0, int'(kerr));  // Still the reset value
        end
        if (ln >= 0 && expect_valid(ln) != 0) begin
            if (valid !== 1'b1) begin
                stop_run($sformatf("valid never arrived for stimulus line %0d", ln + 1));
            end
            check_value("dataout", field(ln, 6), int'(dataout));
            check_value("kerr", field(ln, 7), int'(kerr));
            check_value("rdout", field(ln, 8), int'(rdout));
            exp_rd_now = field(ln, 8);
        end else begin
            check_value("valid", 0, int'(valid));
            check_value("rdout", exp_rd_now, int'(rdout));  // Held over empty cycles
        end
    endtask

    task automatic check_cascade(input int slot);
        int ln;
        ln = line_of(slot);
        if (ln >= 0 && expect_valid(ln) != 0) begin
            check_value("rdcascade", field(ln, 8), int'(rdcascade));
        end
    endtask

    initial begin
        for (int i = 0; i < RUN_TIMEOUT; i++) begin
            @(posedge clk);
        end
        stop_run("simulation did not finish in time");
    end

    initial begin
        int gaps;
        idle_ins   = 1'b0;
        kin        = 1'b0;
        ena        = 1'b0;
        datain     = 8'h00;
        rdin       = 1'b0;
        rdforce    = 1'b0;
        exp_rd_now = 0;
        void'($urandom(89));
        $readmemh("verification/enc_stimulus.txt", stim_mem);

        // Scripted lines with a few random empty cycles between them
        num_slots = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            gaps = 0;
            if (($urandom % 4) == 0) begin
                gaps = 1 + int'($urandom % 2);
            end
            for (int g = 0; g < gaps; g++) begin
                slot_line[num_slots] = -1;
                num_slots++;
            end
            slot_line[num_slots] = i;
            num_slots++;
        end

        wait_for_reset();

        for (int n = 0; n < num_slots + PIPE_DEPTH; n++) begin
            @(negedge clk);
            check_output(n - PIPE_DEPTH);
            drive_symbol(n);
            drive_disparity(n - 2);
            #5;
            check_cascade(n - 2);  // Settled well before the next edge
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verification/enc_stimulus.txt ====
// Columns: idle_ins kin ena datain rdforce rdin | expected code kerr rdout
// rdforce and rdin apply while the word is in the disparity stage
0 0 1 00 0 0 0B9 0 0
0 0 1 B5 0 0 155 0 0
0 0 1 23 0 0 263 0 0
0 0 1 20 0 0 279 0 1
0 0 1 00 0 0 346 0 1
0 0 1 23 0 0 263 0 1
0 0 1 07 0 0 0B8 0 0
0 0 1 F1 0 0 3B1 0 1
0 0 1 F1 0 0 231 0 0
// Control codes in both disparities
0 1 1 BC 0 0 17C 0 1
0 1 1 BC 0 0 283 0 0
0 1 1 1C 0 0 0BC 0 0
0 1 1 3C 0 0 27C 0 1
0 1 1 1C 0 0 343 0 1
0 1 1 5C 0 0 143 0 0
0 1 1 F7 0 0 057 0 0
0 1 1 FB 0 0 05B 0 0
0 1 1 FD 0 0 05D 0 0
0 1 1 FE 0 0 05E 0 0
0 1 1 7C 0 0 33C 0 1
0 1 1 F7 0 0 3A8 0 1
0 1 1 9C 0 0 2C3 0 1
0 1 1 DC 0 0 243 0 0
0 1 1 FC 0 0 07C 0 0
0 1 1 9C 0 0 13C 0 0
0 1 1 3C 0 0 27C 0 1
0 1 1 3C 0 0 183 0 0
0 1 1 BC 0 0 17C 0 1
0 1 1 7C 0 0 0C3 0 0
0 1 1 BC 0 0 17C 0 1
0 1 1 FC 0 0 383 0 1
0 1 1 FB 0 0 3A4 0 1
0 1 1 FD 0 0 3A2 0 1
0 1 1 FE 0 0 3A1 0 1
// Control flag on an illegal byte
0 1 1 00 0 0 283 1 0
// Idle commas, then an empty cycle
1 0 0 00 0 0 17C 0 1
1 0 0 00 0 0 283 0 0
0 0 0 00 0 0 000 0 0
// Forced disparity
0 0 1 20 1 1 246 0 0
0 0 1 20 0 0 279 0 1
0 0 1 00 1 0 0B9 0 0
0 0 1 23 0 0 263 0 0
// Error pattern byte
0 1 1 FF 0 0 23C 1 0

// ==== build.f ====
+incdir+source
source/line_code_pkg.sv
source/lane_pkg.sv
source/symbol_intake.sv
source/data_code_lut.sv
source/ctrl_code_table.sv
source/disparity_select.sv
source/enc8b10b_lane.sv
verification/enc8b10b_lane_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run from the project root
verilator --binary --timing --assert -f build.f --top-module enc8b10b_lane_tb \
    -o enc8b10b_lane_sim \
    && ./obj_dir/enc8b10b_lane_sim | grep "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
